// ==== src/chiplet_types_pkg.sv ====
`default_nettype none

package chiplet_types_pkg;

    // payload bits carried by every flit
    localparam int PAYLOAD_W = 32;

    // position of a flit inside its packet
    typedef enum logic [1:0] {
        FLIT_HEAD   = 2'd0,
        FLIT_BODY   = 2'd1,
        FLIT_TAIL   = 2'd2,
        // a whole packet in one flit
        FLIT_SINGLE = 2'd3
    } flit_kind_e;

    // kind sits in the top two bits
    typedef struct packed {
        flit_kind_e           kind;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    // output arbiter states
    typedef enum logic {
        // free to pick any VC
        ARB_IDLE   = 1'b0,
        // held on one VC until its tail
        ARB_LOCKED = 1'b1
    } arb_state_e;

endpackage

`default_nettype wire

// ==== src/flit_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module flit_rx #(
    parameter int NUM_VCS = 4,
    localparam int VC_W = $clog2(NUM_VCS)
) (
    input  wire logic                                  CLK,
    input  wire logic                                  nRST,
    input  wire logic                                  rx_valid,
    input  wire logic [VC_W-1:0]                       rx_vc,
    input  wire chiplet_types_pkg::flit_t              rx_flit,
    input  wire logic [NUM_VCS-1:0]                    vc_clear,
    output logic [NUM_VCS-1:0]                         wen,
    output chiplet_types_pkg::flit_t [NUM_VCS-1:0]     wdata,
    output logic [NUM_VCS-1:0]                         framing_error
);

    import chiplet_types_pkg::*;

    // one bit per VC, set between head and tail
    logic [NUM_VCS-1:0] in_pkt;
    logic [NUM_VCS-1:0] rx_hit;
    logic               legal;
    logic               in_pkt_next;

    // decode the strobe to the addressed VC
    always_comb begin
        for (int v = 0; v < NUM_VCS; v++) begin
            rx_hit[v] = rx_valid && (int'(rx_vc) == v);
        end
    end

    // framing check against the addressed VC's state
    always_comb begin
        legal       = 1'b0;
        in_pkt_next = in_pkt[rx_vc];
        case (rx_flit.kind)
            FLIT_HEAD: begin
                legal       = !in_pkt[rx_vc];
                in_pkt_next = 1'b1;
            end
            FLIT_BODY:   legal = in_pkt[rx_vc];
            FLIT_TAIL: begin
                legal       = in_pkt[rx_vc];
                in_pkt_next = 1'b0;
            end
            FLIT_SINGLE: legal = !in_pkt[rx_vc];
            default:     legal = 1'b0;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wen           <= '0;
            in_pkt        <= '0;
            framing_error <= '0;
        end else begin
            for (int v = 0; v < NUM_VCS; v++) begin
                wen[v] <= 1'b0;
                if (vc_clear[v]) begin
                    // a flit arriving during clear is dropped too
                    in_pkt[v]        <= 1'b0;
                    framing_error[v] <= 1'b0;
                end else if (rx_hit[v] && legal) begin
                    wen[v]    <= 1'b1;
                    in_pkt[v] <= in_pkt_next;
                end else if (rx_hit[v]) begin
                    framing_error[v] <= 1'b1;
                end
            end
        end
    end

    // write data stage
    always_ff @(posedge CLK) begin
        for (int v = 0; v < NUM_VCS; v++) begin
            if (rx_hit[v]) begin
                wdata[v] <= rx_flit;
            end
        end
    end

    a_rx_vc_range: assert property (@(posedge CLK) disable iff (!nRST)
        rx_valid |-> (int'(rx_vc) < NUM_VCS));

endmodule

`default_nettype wire

// ==== src/vc_buffers.sv ====
`timescale 1ns/10ps
`default_nettype none

module vc_buffers #(
    parameter int NUM_VCS = 4,
    parameter int DEPTH = 8,
    localparam int CNT_W = $clog2(DEPTH+1)
) (
    input  wire logic                                  CLK,
    input  wire logic                                  nRST,
    input  wire logic [NUM_VCS-1:0]                    wen,
    input  wire chiplet_types_pkg::flit_t [NUM_VCS-1:0] wdata,
    input  wire logic [NUM_VCS-1:0]                    ren,
    input  wire logic [NUM_VCS-1:0]                    vc_clear,
    output chiplet_types_pkg::flit_t [NUM_VCS-1:0]     rdata,
    output logic [NUM_VCS-1:0]                         empty,
    output logic [NUM_VCS-1:0]                         buf_full,
    output logic [NUM_VCS-1:0][CNT_W-1:0]              buf_count,
    output logic [NUM_VCS-1:0]                         overrun
);

    import chiplet_types_pkg::*;

    // pointers wrap naturally because DEPTH is a power of two
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
        $error("%m: DEPTH must be a power of two, at least 2");
    end

    flit_t mem [NUM_VCS][DEPTH];

    logic [NUM_VCS-1:0][PTR_W-1:0] wr_ptr;
    logic [NUM_VCS-1:0][PTR_W-1:0] rd_ptr;
    logic [NUM_VCS-1:0]            push;
    logic [NUM_VCS-1:0]            pop;

    // status straight from registered state
    for (genvar v = 0; v < NUM_VCS; v++) begin : g_status
        assign empty[v]    = (buf_count[v] == '0);
        assign buf_full[v] = (int'(buf_count[v]) == DEPTH);
        assign rdata[v]    = mem[v][rd_ptr[v]];
    end

    // clear wins over any push or pop
    always_comb begin
        for (int v = 0; v < NUM_VCS; v++) begin
            push[v] = wen[v] && !buf_full[v] && !vc_clear[v];
            pop[v]  = ren[v] && !empty[v] && !vc_clear[v];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            buf_count <= '0;
            overrun   <= '0;
        end else begin
            for (int v = 0; v < NUM_VCS; v++) begin
                if (vc_clear[v]) begin
                    // stale entries stay, pointers say empty
                    wr_ptr[v]    <= '0;
                    rd_ptr[v]    <= '0;
                    buf_count[v] <= '0;
                    overrun[v]   <= 1'b0;
                end else begin
                    if (push[v]) begin
                        wr_ptr[v] <= wr_ptr[v] + 1'b1;
                    end
                    if (pop[v]) begin
                        rd_ptr[v] <= rd_ptr[v] + 1'b1;
                    end
                    // simultaneous push and pop leaves the count alone
                    case ({push[v], pop[v]})
                        2'b10:   buf_count[v] <= buf_count[v] + 1'b1;
                        2'b01:   buf_count[v] <= buf_count[v] - 1'b1;
                        default: buf_count[v] <= buf_count[v];
                    endcase
                    // write into a full VC is lost
                    if (wen[v] && buf_full[v]) begin
                        overrun[v] <= 1'b1;
                    end
                end
            end
        end
    end

    // storage array
    always_ff @(posedge CLK) begin
        for (int v = 0; v < NUM_VCS; v++) begin
            if (push[v]) begin
                mem[v][wr_ptr[v]] <= wdata[v];
            end
        end
    end

    for (genvar v = 0; v < NUM_VCS; v++) begin : g_checks
        // the arbiter only reads non-empty VCs
        a_no_underrun: assert property (@(posedge CLK) disable iff (!nRST)
            ren[v] |-> !empty[v]);

        a_count_bound: assert property (@(posedge CLK) disable iff (!nRST)
            int'(buf_count[v]) <= DEPTH);
    end

endmodule

`default_nettype wire

// ==== src/vc_tx_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module vc_tx_arbiter #(
    parameter int NUM_VCS = 4,
    localparam int VC_W = $clog2(NUM_VCS)
) (
    input  wire logic                                  CLK,
    input  wire logic                                  nRST,
    input  wire logic [NUM_VCS-1:0]                    empty,
    input  wire chiplet_types_pkg::flit_t [NUM_VCS-1:0] rdata,
    input  wire logic [NUM_VCS-1:0]                    vc_clear,
    input  wire logic                                  tx_stall,
    output logic [NUM_VCS-1:0]                         ren,
    output logic                                       tx_valid,
    output logic [VC_W-1:0]                            tx_vc,
    output chiplet_types_pkg::flit_t                   tx_flit
);

    import chiplet_types_pkg::*;

    arb_state_e         state;
    arb_state_e         state_next;
    logic [VC_W-1:0]    lock_vc;
    logic [VC_W-1:0]    last_vc;
    logic [VC_W-1:0]    grant_vc;
    logic               grant;
    logic [NUM_VCS-1:0] avail;

    // a VC being cleared is not eligible
    assign avail = ~empty & ~vc_clear;

    always_comb begin
        int idx;
        grant    = 1'b0;
        grant_vc = lock_vc;
        idx      = 0;
        if (!tx_stall) begin
            if (state == ARB_IDLE) begin
                // round robin, starting after the last grant
                for (int i = 1; i <= NUM_VCS; i++) begin
                    idx = int'(last_vc) + i;
                    if (idx >= NUM_VCS) begin
                        idx = idx - NUM_VCS;
                    end
                    if (!grant && avail[idx]) begin
                        grant    = 1'b1;
                        grant_vc = VC_W'(idx);
                    end
                end
            end else begin
                grant = avail[lock_vc];
            end
        end
        ren = '0;
        if (grant) begin
            ren[grant_vc] = 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ARB_IDLE: begin
                if (grant && rdata[grant_vc].kind == FLIT_HEAD) begin
                    state_next = ARB_LOCKED;
                end
            end
            ARB_LOCKED: begin
                if (vc_clear[lock_vc]) begin
                    state_next = ARB_IDLE;
                end else if (grant && rdata[grant_vc].kind == FLIT_TAIL) begin
                    state_next = ARB_IDLE;
                end
            end
            default: state_next = ARB_IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state    <= ARB_IDLE;
            lock_vc  <= '0;
            // so the first search starts at VC 0
            last_vc  <= VC_W'(NUM_VCS - 1);
            tx_valid <= 1'b0;
        end else begin
            state    <= state_next;
            tx_valid <= grant;
            if (grant) begin
                last_vc <= grant_vc;
                lock_vc <= grant_vc;
            end
        end
    end

    // outgoing flit, captured at the pop
    always_ff @(posedge CLK) begin
        if (grant) begin
            tx_vc   <= grant_vc;
            tx_flit <= rdata[grant_vc];
        end
    end

    a_ren_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(ren));

    a_no_pop_stalled: assert property (@(posedge CLK) disable iff (!nRST)
        tx_stall |-> (ren == '0));

endmodule

`default_nettype wire

// ==== src/chiplet_rx_buffers.sv ====
`timescale 1ns/10ps
`default_nettype none

module chiplet_rx_buffers #(
    parameter int NUM_VCS = 4,
    parameter int DEPTH = 8,
    localparam int VC_W = $clog2(NUM_VCS),
    localparam int CNT_W = $clog2(DEPTH+1)
) (
    input  wire logic                        CLK,
    input  wire logic                        nRST,
    input  wire logic                        rx_valid,
    input  wire logic [VC_W-1:0]             rx_vc,
    input  wire chiplet_types_pkg::flit_t    rx_flit,
    input  wire logic [NUM_VCS-1:0]          vc_clear,
    input  wire logic                        tx_stall,
    output logic                             tx_valid,
    output logic [VC_W-1:0]                  tx_vc,
    output chiplet_types_pkg::flit_t         tx_flit,
    output logic [NUM_VCS-1:0][CNT_W-1:0]    buf_count,
    output logic [NUM_VCS-1:0]               buf_full,
    output logic [NUM_VCS-1:0]               overrun,
    output logic [NUM_VCS-1:0]               framing_error
);

    import chiplet_types_pkg::*;

    // rx stage to buffers
    logic [NUM_VCS-1:0]  wen;
    flit_t [NUM_VCS-1:0] wdata;

    // buffers to arbiter
    logic [NUM_VCS-1:0]  ren;
    flit_t [NUM_VCS-1:0] rdata;
    logic [NUM_VCS-1:0]  empty;

    flit_rx #(
        .NUM_VCS(NUM_VCS)
    ) i_flit_rx (
        .CLK           (CLK),
        .nRST          (nRST),
        .rx_valid      (rx_valid),
        .rx_vc         (rx_vc),
        .rx_flit       (rx_flit),
        .vc_clear      (vc_clear),
        .wen           (wen),
        .wdata         (wdata),
        .framing_error (framing_error)
    );

    vc_buffers #(
        .NUM_VCS(NUM_VCS),
        .DEPTH  (DEPTH)
    ) i_vc_buffers (
        .CLK       (CLK),
        .nRST      (nRST),
        .wen       (wen),
        .wdata     (wdata),
        .ren       (ren),
        .vc_clear  (vc_clear),
        .rdata     (rdata),
        .empty     (empty),
        .buf_full  (buf_full),
        .buf_count (buf_count),
        .overrun   (overrun)
    );

    vc_tx_arbiter #(
        .NUM_VCS(NUM_VCS)
    ) i_vc_tx_arbiter (
        .CLK      (CLK),
        .nRST     (nRST),
        .empty    (empty),
        .rdata    (rdata),
        .vc_clear (vc_clear),
        .tx_stall (tx_stall),
        .ren      (ren),
        .tx_valid (tx_valid),
        .tx_vc    (tx_vc),
        .tx_flit  (tx_flit)
    );

endmodule

`default_nettype wire

// ==== test/tb_rx_model.svh ====
logic [31:0] lfsr;

// reference queues, one per VC, holding what the buffers should hold
flit_t              model_q [NUM_VCS][$];
logic [NUM_VCS-1:0] model_in_pkt;
logic [NUM_VCS-1:0] model_ferr;
logic [NUM_VCS-1:0] model_ovr;

// flit strobed last cycle, reaches its queue one cycle later
logic               pend_valid;
logic [VC_W-1:0]    pend_vc;
flit_t              pend_flit;

// VC held by the last head seen on tx, -1 when free
int                 lock_vc;
int                 sent_cnt [NUM_VCS];
logic               stall_prev;

// galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        r    = {r[30:0], lfsr[0]};
    end
    return r;
endfunction

function automatic int queued_total();
    int n;
    n = 0;
    for (int v = 0; v < NUM_VCS; v++) begin
        n += model_q[v].size();
    end
    return n;
endfunction

task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        errors++;
        $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
endtask

// ==== test/tb_chiplet_rx_buffers.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_chiplet_rx_buffers;

    import chiplet_types_pkg::*;

    localparam int NUM_VCS = 4;
    localparam int DEPTH = 8;
    localparam int VC_W = $clog2(NUM_VCS);
    localparam int CNT_W = $clog2(DEPTH+1);

    logic                          CLK;
    logic                          nRST;
    logic                          rx_valid;
    logic [VC_W-1:0]               rx_vc;
    flit_t                         rx_flit;
    logic [NUM_VCS-1:0]            vc_clear;
    logic                          tx_stall;
    logic                          tx_valid;
    logic [VC_W-1:0]               tx_vc;
    flit_t                         tx_flit;
    logic [NUM_VCS-1:0][CNT_W-1:0] buf_count;
    logic [NUM_VCS-1:0]            buf_full;
    logic [NUM_VCS-1:0]            overrun;
    logic [NUM_VCS-1:0]            framing_error;

    int errors;
    int tests;
    int failed_tests;
    int test_start;

    `include "tb_rx_model.svh"

    chiplet_rx_buffers i_chiplet_rx_buffers (.*);

    always #50 CLK = ~CLK;

    // check outputs, advance the model and drive new inputs on one falling edge
    task automatic step_cycle(input logic valid, input logic [VC_W-1:0] vc, input flit_t flit,
                              input logic [NUM_VCS-1:0] clear, input logic stall);
        flit_t exp_flit;
        logic  legal;
        @(negedge CLK);
        // tx_valid shows the pop at the last rising edge
        if (tx_valid) begin
            if (stall_prev) begin
                errors++;
                $display("A flit was sent on VC %0d while tx_stall was high", tx_vc);
            end
            if (lock_vc >= 0) begin
                compare("tx_vc", tx_vc, lock_vc);
            end
            if (model_q[tx_vc].size() == 0) begin
                errors++;
                $display("VC %0d sent a flit that was never stored, at %0t", tx_vc, $time);
            end else begin
                exp_flit = model_q[tx_vc].pop_front();
                compare("tx_flit", tx_flit, exp_flit);
                if (exp_flit.kind == FLIT_HEAD) begin
                    lock_vc = tx_vc;
                end else if (exp_flit.kind == FLIT_TAIL) begin
                    lock_vc = -1;
                end
            end
            sent_cnt[tx_vc]++;
        end
        for (int v = 0; v < NUM_VCS; v++) begin
            compare($sformatf("buf_count[%0d]", v), buf_count[v], model_q[v].size());
            compare($sformatf("buf_full[%0d]", v), buf_full[v], model_q[v].size() == DEPTH);
            compare($sformatf("overrun[%0d]", v), overrun[v], model_ovr[v]);
            compare($sformatf("framing_error[%0d]", v), framing_error[v], model_ferr[v]);
        end
        // last cycle's strobe is written at the coming edge
        if (pend_valid) begin
            if (model_q[pend_vc].size() < DEPTH) begin
                model_q[pend_vc].push_back(pend_flit);
            end else begin
                model_ovr[pend_vc] = 1'b1;
            end
        end
        pend_valid = 1'b0;
        for (int v = 0; v < NUM_VCS; v++) begin
            if (clear[v]) begin
                model_q[v].delete();
                model_in_pkt[v] = 1'b0;
                model_ferr[v]   = 1'b0;
                model_ovr[v]    = 1'b0;
                if (lock_vc == v) begin
                    lock_vc = -1;
                end
            end
        end
        if (valid && !clear[vc]) begin
            legal = (flit.kind == FLIT_HEAD || flit.kind == FLIT_SINGLE) ?
                    !model_in_pkt[vc] : model_in_pkt[vc];
            if (legal) begin
                pend_valid = 1'b1;
                pend_vc    = vc;
                pend_flit  = flit;
                if (flit.kind == FLIT_HEAD) begin
                    model_in_pkt[vc] = 1'b1;
                end else if (flit.kind == FLIT_TAIL) begin
                    model_in_pkt[vc] = 1'b0;
                end
            end else begin
                model_ferr[vc] = 1'b1;
            end
        end
        rx_valid   = valid;
        rx_vc      = vc;
        rx_flit    = flit;
        vc_clear   = clear;
        tx_stall   = stall;
        stall_prev = stall;
    endtask

    task automatic idle_cycle(input logic stall);
        step_cycle(1'b0, '0, '0, '0, stall);
    endtask

    function automatic flit_t make_flit(input flit_kind_e kind);
        flit_t f;
        f.kind    = kind;
        f.payload = rand_bits(PAYLOAD_W);
        return f;
    endfunction

    // kind chosen legal or illegal against the VC's framing state
    function automatic flit_t random_flit(input logic [VC_W-1:0] vc, input logic legal);
        logic r;
        r = (rand_bits(1) == 32'd1);
        if (model_in_pkt[vc] == legal) begin
            return make_flit(r ? FLIT_BODY : FLIT_TAIL);
        end
        return make_flit(r ? FLIT_HEAD : FLIT_SINGLE);
    endfunction

    task automatic random_traffic(input int cycles, input logic allow_bad);
        logic            valid;
        logic [VC_W-1:0] vc;
        logic            legal;
        for (int i = 0; i < cycles; i++) begin
            valid = (rand_bits(1) == 32'd1);
            vc    = VC_W'(rand_bits(VC_W));
            legal = !(allow_bad && rand_bits(3) == 32'd0);
            // keep clear of overrun so packets stay whole
            if (model_q[vc].size() >= DEPTH - 2) begin
                valid = 1'b0;
            end
            step_cycle(valid, vc, random_flit(vc, legal), '0, 1'b0);
        end
    endtask

    task automatic close_packets();
        for (int v = 0; v < NUM_VCS; v++) begin
            if (model_in_pkt[v]) begin
                step_cycle(1'b1, VC_W'(v), make_flit(FLIT_TAIL), '0, 1'b0);
            end
        end
    endtask

    task automatic drain_buffers();
        int n;
        n = 0;
        idle_cycle(1'b0);
        while ((queued_total() != 0 || pend_valid) && n < 100) begin
            idle_cycle(1'b0);
            n++;
        end
        if (n >= 100) begin
            errors++;
            $display("Timeout waiting for the buffers to drain");
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != test_start) begin
            failed_tests++;
            $display("test %-12s : %0d errors", name, errors - test_start);
        end else begin
            $display("test %-12s : ok", name);
        end
        test_start = errors;
    endtask

    initial begin
        logic [NUM_VCS-1:0] clear_one;
        int                 n;
        CLK          = 1'b0;
        nRST         = 1'b0;
        rx_valid     = 1'b0;
        rx_vc        = '0;
        rx_flit      = '0;
        vc_clear     = '0;
        tx_stall     = 1'b0;
        lfsr         = 32'h3948_506f;
        model_in_pkt = '0;
        model_ferr   = '0;
        model_ovr    = '0;
        pend_valid   = 1'b0;
        pend_vc      = '0;
        pend_flit    = '0;
        lock_vc      = -1;
        stall_prev   = 1'b0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        test_start   = 0;
        foreach (sent_cnt[v]) begin
            sent_cnt[v] = 0;
        end
        repeat (8) @(negedge CLK);
        nRST = 1'b1;

        idle_cycle(1'b0);
        compare("tx_valid", tx_valid, 1'b0);
        compare("overrun", overrun, '0);
        compare("framing_error", framing_error, '0);
        compare("buf_count", buf_count, '0);
        finish_test("reset");

        random_traffic(400, 1'b0);
        close_packets();
        drain_buffers();
        finish_test("ordering");

        // a body outside a packet and then a head inside one
        step_cycle(1'b1, VC_W'(2), make_flit(FLIT_BODY), '0, 1'b0);
        idle_cycle(1'b0);
        compare("framing_error[2]", framing_error[2], 1'b1);
        step_cycle(1'b1, VC_W'(2), make_flit(FLIT_HEAD), '0, 1'b0);
        step_cycle(1'b1, VC_W'(2), make_flit(FLIT_HEAD), '0, 1'b0);
        step_cycle(1'b1, VC_W'(2), make_flit(FLIT_BODY), '0, 1'b0);
        step_cycle(1'b1, VC_W'(2), make_flit(FLIT_TAIL), '0, 1'b0);
        random_traffic(200, 1'b1);
        close_packets();
        drain_buffers();
        finish_test("framing");

        for (int i = 0; i < DEPTH + 2; i++) begin
            step_cycle(1'b1, VC_W'(1), make_flit(FLIT_SINGLE), '0, 1'b1);
        end
        n = 0;
        while (!overrun[1] && n < 20) begin
            idle_cycle(1'b1);
            n++;
        end
        if (n >= 20) begin
            errors++;
            $display("Timeout waiting for VC 1 to flag overrun");
        end
        compare("buf_count[1]", buf_count[1], DEPTH);
        compare("buf_full[1]", buf_full[1], 1'b1);
        sent_cnt[1] = 0;
        drain_buffers();
        compare("flits sent on VC 1", sent_cnt[1], DEPTH);
        finish_test("backpressure");

        // load VC 1 with two flits and a framing error and VC 2 with one packet
        step_cycle(1'b1, VC_W'(1), make_flit(FLIT_SINGLE), '0, 1'b1);
        step_cycle(1'b1, VC_W'(2), make_flit(FLIT_HEAD), '0, 1'b1);
        step_cycle(1'b1, VC_W'(1), make_flit(FLIT_SINGLE), '0, 1'b1);
        step_cycle(1'b1, VC_W'(2), make_flit(FLIT_BODY), '0, 1'b1);
        step_cycle(1'b1, VC_W'(1), make_flit(FLIT_BODY), '0, 1'b1);
        step_cycle(1'b1, VC_W'(2), make_flit(FLIT_TAIL), '0, 1'b1);
        idle_cycle(1'b1);
        idle_cycle(1'b1);
        sent_cnt[1] = 0;
        sent_cnt[2] = 0;
        clear_one    = '0;
        clear_one[1] = 1'b1;
        step_cycle(1'b0, '0, '0, clear_one, 1'b0);
        idle_cycle(1'b0);
        compare("buf_count[1]", buf_count[1], 0);
        compare("overrun[1]", overrun[1], 1'b0);
        compare("framing_error[1]", framing_error[1], 1'b0);
        drain_buffers();
        compare("flits sent on VC 1", sent_cnt[1], 0);
        compare("flits sent on VC 2", sent_cnt[2], 3);
        finish_test("clear");

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+test
src/chiplet_types_pkg.sv
src/flit_rx.sv
src/vc_buffers.sv
src/vc_tx_arbiter.sv
src/chiplet_rx_buffers.sv
test/tb_chiplet_rx_buffers.sv

// ==== Bender.yml ====
package:
  name: chiplet_rx_buffers

sources:
  - src/chiplet_types_pkg.sv
  - src/flit_rx.sv
  - src/vc_buffers.sv
  - src/vc_tx_arbiter.sv
  - src/chiplet_rx_buffers.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_chiplet_rx_buffers.sv
